/* Makefile */
SIM      = verilator
FLAGS    = --binary --assert -Wno-fatal -j 0
TOP      = tb_frontend
FILELIST = src.f
OBJ_DIR  = obj_dir

SOURCES  = $(shell grep -v '^+' $(FILELIST))
BIN      = $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; \
	echo "$$out" | grep -qx "All checks passed"

clean:
	rm -rf $(OBJ_DIR)

/* rtl/branch_resolver.sv */
// ==================================================
// branch resolver
// checks the head packet against the real outcome,
// registers redirect and training
// ==================================================

`timescale 1ns/1ps

module branch_resolver (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     empty,
  input  frontend_pkg::fetch_pkt_t head,
  input  logic                     resolve,
  input  logic                     actual_taken,
  input  frontend_pkg::ip_t        actual_target,
  output logic                     pop,
  output logic                     head_valid,
  train_if.source                  train_port
);

  frontend_pkg::ip_t   head_ip;
  frontend_pkg::ip_t   head_target;
  logic                head_taken;
  frontend_pkg::hist_t head_hist;
  logic                mispredict;
  frontend_pkg::ip_t   correct_ip;

  assign head_ip     = head[frontend_pkg::PKT_IP_LSB +: frontend_pkg::IP_W];
  assign head_target = head[frontend_pkg::PKT_TGT_LSB +: frontend_pkg::IP_W];
  assign head_taken  = head[frontend_pkg::PKT_TAKEN_BIT];
  assign head_hist   = head[frontend_pkg::PKT_HIST_LSB +: frontend_pkg::HIST_W];

  assign mispredict = (head_taken != actual_taken)
                    | (head_taken & actual_taken & (head_target != actual_target));
  assign correct_ip = actual_taken ? actual_target
                                   : head_ip + frontend_pkg::ip_t'(frontend_pkg::BLOCK_BYTES);

  // head is stale while the flush is pending
  assign head_valid = ~empty & ~train_port.redirect;
  assign pop        = resolve & head_valid;

  always_ff @(posedge clk) begin
    if (rst) begin
      train_port.redirect <= 1'b0;
      train_port.train_en <= 1'b0;
    end else begin
      train_port.redirect <= pop & mispredict;
      train_port.train_en <= pop; // train on every resolve
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      train_port.redirect_ip  <= correct_ip;
      train_port.train_ip     <= head_ip;
      train_port.train_taken  <= actual_taken;
      train_port.train_target <= actual_target;
      train_port.train_hist   <= head_hist;
    end
  end

endmodule

/* rtl/branch_target_buffer.sv */
// ==================================================
// direct mapped branch target buffer
// one tagged entry per set, combinational lookup
// ==================================================

`timescale 1ns/1ps

module branch_target_buffer #(
  parameter int BTB_ENTRIES = 64
) (
  input  logic              clk,
  input  logic              rst,
  input  frontend_pkg::ip_t lookup_ip,
  input  logic              wr_en,
  input  frontend_pkg::ip_t wr_ip,
  input  frontend_pkg::ip_t wr_target,
  output logic              hit,
  output frontend_pkg::ip_t target
);

  localparam int IDX_W = $clog2(BTB_ENTRIES);
  localparam int TAG_W = frontend_pkg::IP_W - frontend_pkg::OFFSET_W - IDX_W;

  logic [BTB_ENTRIES-1:0]     valid_q;
  logic [TAG_W-1:0]           tag_q [BTB_ENTRIES];
  frontend_pkg::ip_t          target_q [BTB_ENTRIES];

  logic [IDX_W-1:0] rd_idx;
  logic [TAG_W-1:0] rd_tag;
  logic [IDX_W-1:0] wr_idx;
  logic [TAG_W-1:0] wr_tag;

  // index sits right above the block offset, tag is the rest
  assign rd_idx = lookup_ip[frontend_pkg::OFFSET_W +: IDX_W];
  assign rd_tag = lookup_ip[frontend_pkg::IP_W-1 -: TAG_W];
  assign wr_idx = wr_ip[frontend_pkg::OFFSET_W +: IDX_W];
  assign wr_tag = wr_ip[frontend_pkg::IP_W-1 -: TAG_W];

  assign hit    = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
  assign target = target_q[rd_idx];

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (wr_en) begin
      valid_q[wr_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      tag_q[wr_idx]    <= wr_tag;
      target_q[wr_idx] <= wr_target; // replaces whatever lived in the set
    end
  end

endmodule

/* rtl/direction_predictor.sv */
// ==================================================
// global history direction predictor
// 2-bit saturating counters, gshare style index
// ==================================================

`timescale 1ns/1ps

module direction_predictor #(
  parameter int PHT_ENTRIES = 256
) (
  input  logic                clk,
  input  logic                rst,
  input  frontend_pkg::ip_t   lookup_ip,
  input  frontend_pkg::hist_t lookup_hist,
  input  logic                upd_en,
  input  frontend_pkg::ip_t   upd_ip,
  input  frontend_pkg::hist_t upd_hist,
  input  logic                upd_taken,
  output logic                taken
);

  localparam int IDX_W = $clog2(PHT_ENTRIES);

  frontend_pkg::ctr_t pht_q [PHT_ENTRIES];

  logic [IDX_W-1:0] rd_idx;
  logic [IDX_W-1:0] upd_idx;
  frontend_pkg::ctr_t upd_ctr;

  // block bits of the ip xor the history in the low bits
  function automatic logic [IDX_W-1:0] pht_index(input frontend_pkg::ip_t ip,
                                                 input frontend_pkg::hist_t hist);
    pht_index = IDX_W'(ip >> frontend_pkg::OFFSET_W) ^ IDX_W'(hist);
  endfunction

  assign rd_idx  = pht_index(lookup_ip, lookup_hist);
  assign upd_idx = pht_index(upd_ip, upd_hist);
  assign upd_ctr = pht_q[upd_idx];
  assign taken   = pht_q[rd_idx][1];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < PHT_ENTRIES; i++) begin
        pht_q[i] <= frontend_pkg::CTR_INIT;
      end
    end else if (upd_en) begin
      if (upd_taken && upd_ctr != 2'b11) begin
        pht_q[upd_idx] <= upd_ctr + 2'd1;
      end else if (!upd_taken && upd_ctr != 2'b00) begin
        pht_q[upd_idx] <= upd_ctr - 2'd1;
      end
    end
  end

endmodule

/* rtl/fetch_ip_gen.sv */
// ==================================================
// fetch ip sequencer
// holds ip and global history, predicts the next
// block, pushes packets and takes redirects
// ==================================================

`timescale 1ns/1ps

module fetch_ip_gen #(
  parameter int BTB_ENTRIES = 64,
  parameter int PHT_ENTRIES = 256
) (
  input logic            clk,
  input logic            rst,
  fetch_push_if.producer push_port,
  train_if.sink          train_port
);

  frontend_pkg::ip_t   ip_q;
  frontend_pkg::hist_t hist_q;
  logic                active_q; // low for the first cycle out of reset

  logic              btb_hit;
  frontend_pkg::ip_t btb_target;
  logic              pht_taken;
  logic              pred_taken;
  frontend_pkg::ip_t seq_ip;
  frontend_pkg::ip_t next_ip;

  branch_target_buffer #(
    .BTB_ENTRIES(BTB_ENTRIES)
  ) u_btb (
    .clk       (clk),
    .rst       (rst),
    .lookup_ip (ip_q),
    .wr_en     (train_port.train_en & train_port.train_taken), // taken branches only
    .wr_ip     (train_port.train_ip),
    .wr_target (train_port.train_target),
    .hit       (btb_hit),
    .target    (btb_target)
  );

  direction_predictor #(
    .PHT_ENTRIES(PHT_ENTRIES)
  ) u_pht (
    .clk         (clk),
    .rst         (rst),
    .lookup_ip   (ip_q),
    .lookup_hist (hist_q),
    .upd_en      (train_port.train_en),
    .upd_ip      (train_port.train_ip),
    .upd_hist    (train_port.train_hist),
    .upd_taken   (train_port.train_taken),
    .taken       (pht_taken)
  );

  assign seq_ip     = ip_q + frontend_pkg::ip_t'(frontend_pkg::BLOCK_BYTES);
  assign pred_taken = btb_hit & pht_taken;
  assign next_ip    = pred_taken ? btb_target : seq_ip;

  // no push while redirecting since the queue flushes anyway
  assign push_port.push = active_q & ~push_port.full & ~train_port.redirect;
  assign push_port.pkt  = {ip_q, next_ip, pred_taken, hist_q}; // pred_target is the next fetch ip

  always_ff @(posedge clk) begin
    if (rst) begin
      ip_q     <= frontend_pkg::RESET_IP;
      hist_q   <= '0;
      active_q <= 1'b0;
    end else begin
      active_q <= 1'b1;
      if (train_port.redirect) begin
        // restart from the resolved path with the real outcome in history
        ip_q   <= train_port.redirect_ip;
        hist_q <= {train_port.train_hist[frontend_pkg::HIST_W-2:0], train_port.train_taken};
      end else if (push_port.push) begin
        ip_q   <= next_ip;
        hist_q <= {hist_q[frontend_pkg::HIST_W-2:0], pred_taken};
      end
    end
  end

endmodule

/* rtl/fetch_queue.sv */
// ==================================================
// fetch packet FIFO between sequencer and resolver
// circular buffer with count and flush
// ==================================================

`timescale 1ns/1ps

module fetch_queue #(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic                     clk,
  input  logic                     rst,
  fetch_push_if.buffer             push_port,
  input  logic                     pop,
  input  logic                     flush,
  output logic                     empty,
  output frontend_pkg::fetch_pkt_t head
);

  localparam int PTR_W = $clog2(QUEUE_DEPTH);

  frontend_pkg::fetch_pkt_t mem_q [QUEUE_DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W:0]   count_q;
  logic             do_pop;

  assign empty          = (count_q == '0);
  assign push_port.full = (count_q == (PTR_W+1)'(QUEUE_DEPTH));
  assign head           = mem_q[rd_ptr_q];
  assign do_pop         = pop & ~empty;

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_port.push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1; // wraps at the power of two
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push_port.push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // a write during flush lands in a slot that is discarded
  always_ff @(posedge clk) begin
    if (push_port.push) begin
      mem_q[wr_ptr_q] <= push_port.pkt;
    end
  end

endmodule

/* rtl/frontend_ifs.sv */
// ==================================================
// fetch_push_if  producer to fetch queue link
// train_if       resolver redirect and training bus
// ==================================================

`timescale 1ns/1ps

interface fetch_push_if;
  logic                    push;
  frontend_pkg::fetch_pkt_t pkt;
  logic                    full;

  // push only while full is low
  modport producer (
    output push,
    output pkt,
    input  full
  );

  modport buffer (
    input  push,
    input  pkt,
    output full
  );
endinterface

interface train_if;
  logic                redirect;     // one cycle pulse
  frontend_pkg::ip_t   redirect_ip;
  logic                train_en;     // one per resolve
  frontend_pkg::ip_t   train_ip;
  logic                train_taken;
  frontend_pkg::ip_t   train_target;
  frontend_pkg::hist_t train_hist;

  modport source (
    output redirect,
    output redirect_ip,
    output train_en,
    output train_ip,
    output train_taken,
    output train_target,
    output train_hist
  );

  modport sink (
    input redirect,
    input redirect_ip,
    input train_en,
    input train_ip,
    input train_taken,
    input train_target,
    input train_hist
  );
endinterface

/* rtl/frontend_pkg.sv */
// ==================================================
// fetch front end shared definitions
// widths, vector typedefs, reset values and the
// fetch packet layout
// ==================================================

package frontend_pkg;

  localparam int IP_W        = 32;
  localparam int HIST_W      = 8;
  localparam int BLOCK_BYTES = 16;
  localparam int OFFSET_W    = $clog2(BLOCK_BYTES); // byte offset inside a fetch block

  typedef logic [IP_W-1:0]   ip_t;
  typedef logic [HIST_W-1:0] hist_t;
  typedef logic [1:0]        ctr_t;

  localparam ctr_t CTR_INIT = 2'b01;         // weakly not taken
  localparam ip_t  RESET_IP = 32'h0000_1000;

  // fetch packet from the msb down holds ip, pred_target, pred_taken and hist
  // hist is the lookup history before this block's bit
  localparam int PKT_HIST_LSB  = 0;
  localparam int PKT_TAKEN_BIT = PKT_HIST_LSB + HIST_W;
  localparam int PKT_TGT_LSB   = PKT_TAKEN_BIT + 1;
  localparam int PKT_IP_LSB    = PKT_TGT_LSB + IP_W;
  localparam int PKT_W         = PKT_IP_LSB + IP_W;  // 73 bits

  typedef logic [PKT_W-1:0] fetch_pkt_t;

endpackage

/* rtl/frontend_top.sv */
// ==================================================
// fetch front end top level
// sequencer, fetch queue and resolver
// ==================================================

`timescale 1ns/1ps

module frontend_top #(
  parameter int QUEUE_DEPTH = 4,
  parameter int BTB_ENTRIES = 64,
  parameter int PHT_ENTRIES = 256
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              resolve,
  input  logic              actual_taken,
  input  frontend_pkg::ip_t actual_target,
  output logic              head_valid,
  output frontend_pkg::ip_t head_ip,
  output logic              head_pred_taken,
  output frontend_pkg::ip_t head_pred_target,
  output logic              redirect,
  output frontend_pkg::ip_t redirect_ip
);

  fetch_push_if push_bus ();
  train_if      train_bus ();

  logic                     empty;
  logic                     pop;
  frontend_pkg::fetch_pkt_t head;

  fetch_ip_gen #(
    .BTB_ENTRIES(BTB_ENTRIES),
    .PHT_ENTRIES(PHT_ENTRIES)
  ) u_ip_gen (
    .clk        (clk),
    .rst        (rst),
    .push_port  (push_bus),
    .train_port (train_bus)
  );

  fetch_queue #(
    .QUEUE_DEPTH(QUEUE_DEPTH)
  ) u_queue (
    .clk       (clk),
    .rst       (rst),
    .push_port (push_bus),
    .pop       (pop),
    .flush     (train_bus.redirect),
    .empty     (empty),
    .head      (head)
  );

  branch_resolver u_resolver (
    .clk           (clk),
    .rst           (rst),
    .empty         (empty),
    .head          (head),
    .resolve       (resolve),
    .actual_taken  (actual_taken),
    .actual_target (actual_target),
    .pop           (pop),
    .head_valid    (head_valid),
    .train_port    (train_bus)
  );

  assign head_ip          = head[frontend_pkg::PKT_IP_LSB +: frontend_pkg::IP_W];
  assign head_pred_target = head[frontend_pkg::PKT_TGT_LSB +: frontend_pkg::IP_W];
  assign head_pred_taken  = head[frontend_pkg::PKT_TAKEN_BIT];
  assign redirect         = train_bus.redirect;
  assign redirect_ip      = train_bus.redirect_ip;

endmodule

/* src.f */
rtl/frontend_pkg.sv
rtl/frontend_ifs.sv
rtl/branch_target_buffer.sv
rtl/direction_predictor.sv
rtl/fetch_ip_gen.sv
rtl/fetch_queue.sv
rtl/branch_resolver.sv
rtl/frontend_top.sv
tb/frontend_properties.sv
tb/tb_frontend.sv

/* tb/frontend_properties.sv */
// ==================================================
// bound checks on queue and redirect behaviour
// push vs full, pop vs empty, redirect pulse width
// and an empty queue after each flush
// ==================================================

`timescale 1ns/1ps

module frontend_properties (
  input logic clk,
  input logic rst,
  input logic push,
  input logic full,
  input logic pop,
  input logic empty,
  input logic redirect,
  input logic head_valid
);

  no_push_when_full: assert property (@(posedge clk) disable iff (rst) push |-> !full)
    else $error("packet pushed into a full fetch queue");

  no_pop_when_empty: assert property (@(posedge clk) disable iff (rst) pop |-> !empty)
    else $error("pop issued while the fetch queue is empty");

  redirect_one_cycle: assert property (@(posedge clk) disable iff (rst) redirect |=> !redirect)
    else $error("redirect held longer than one cycle");

  no_head_after_redirect: assert property (@(posedge clk) disable iff (rst)
                                           redirect |=> !head_valid)
    else $error("head_valid high in the cycle after a redirect");

endmodule

// on the queue side a head is any stored packet
bind fetch_queue frontend_properties u_queue_props (
  .clk        (clk),
  .rst        (rst),
  .push       (push_port.push),
  .full       (push_port.full),
  .pop        (pop),
  .empty      (empty),
  .redirect   (flush),
  .head_valid (!empty)
);

bind branch_resolver frontend_properties u_resolver_props (
  .clk        (clk),
  .rst        (rst),
  .push       (1'b0),
  .full       (1'b0),
  .pop        (pop),
  .empty      (empty),
  .redirect   (train_port.redirect),
  .head_valid (head_valid)
);

/* tb/tb_frontend.sv */
// ==================================================
// testbench for the fetch front end
// random branch outcomes, cycle model of queue,
// BTB, counter table and history, watchdog
// ==================================================

`timescale 1ns/1ps

module tb_frontend;

  localparam int QUEUE_DEPTH  = 4;
  localparam int BTB_ENTRIES  = 64;
  localparam int PHT_ENTRIES  = 256;
  localparam int PERIOD       = 100;
  localparam int RESET_CYCLES = 8;
  localparam int NUM_RESOLVES = 3000;
  localparam int TEST_CYCLES  = NUM_RESOLVES + RESET_CYCLES;
  localparam int NUM_BR       = 8;
  localparam int HW           = frontend_pkg::HIST_W;
  localparam frontend_pkg::ip_t STEP = 32'(frontend_pkg::BLOCK_BYTES);

  logic              clk;
  logic              rst;
  logic              resolve;
  logic              actual_taken;
  frontend_pkg::ip_t actual_target;
  logic              head_valid;
  frontend_pkg::ip_t head_ip;
  logic              head_pred_taken;
  frontend_pkg::ip_t head_pred_target;
  logic              redirect;
  frontend_pkg::ip_t redirect_ip;

  int   seed = 6332;
  int   err_count;
  int   resolves;
  int   cycle;
  logic saw_full;
  logic seen_head;

  // outcome table with branches recurring inside a 512 byte window
  frontend_pkg::ip_t br_ip [NUM_BR];
  frontend_pkg::ip_t br_tgt [NUM_BR];
  int                br_bias [NUM_BR]; // taken chance in quarters

  // reference model state
  frontend_pkg::ip_t        m_ip;
  frontend_pkg::hist_t      m_hist;
  logic                     m_active;
  frontend_pkg::fetch_pkt_t m_q [$];
  logic                     m_redir;
  frontend_pkg::ip_t        m_redir_ip;
  logic                     m_tr_en;
  logic                     m_tr_taken;
  frontend_pkg::ip_t        m_tr_ip;
  frontend_pkg::ip_t        m_tr_tgt;
  frontend_pkg::hist_t      m_tr_hist;
  logic                     m_btb_valid [BTB_ENTRIES];
  int unsigned              m_btb_tag [BTB_ENTRIES];
  frontend_pkg::ip_t        m_btb_tgt [BTB_ENTRIES];
  frontend_pkg::ctr_t       m_pht [PHT_ENTRIES];

  frontend_top #(
    .QUEUE_DEPTH(QUEUE_DEPTH),
    .BTB_ENTRIES(BTB_ENTRIES),
    .PHT_ENTRIES(PHT_ENTRIES)
  ) u_dut (
    .clk              (clk),
    .rst              (rst),
    .resolve          (resolve),
    .actual_taken     (actual_taken),
    .actual_target    (actual_target),
    .head_valid       (head_valid),
    .head_ip          (head_ip),
    .head_pred_taken  (head_pred_taken),
    .head_pred_target (head_pred_target),
    .redirect         (redirect),
    .redirect_ip      (redirect_ip)
  );

  initial begin
    clk = 1'b0;
    forever #(PERIOD/2) clk = ~clk;
  end

  initial begin
    #(longint'(20) * TEST_CYCLES * PERIOD);
    $display("Checks failed");
    $fatal(1, "timeout, the run did not finish %0d resolves in time", NUM_RESOLVES);
  end

  function automatic int unsigned btb_idx(input frontend_pkg::ip_t ip);
    return (ip / STEP) % BTB_ENTRIES;
  endfunction

  function automatic int unsigned btb_tag(input frontend_pkg::ip_t ip);
    return ip / (STEP * BTB_ENTRIES);
  endfunction

  function automatic int unsigned pht_idx(input frontend_pkg::ip_t ip,
                                          input frontend_pkg::hist_t hist);
    return ((ip / STEP) ^ hist) % PHT_ENTRIES;
  endfunction

  task automatic check_val(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp) begin
      err_count++;
      $display("FAIL %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
      $display("Checks failed");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  task automatic init_branches();
    // entry 0 closes the window so the path keeps coming back
    br_ip[0]   = frontend_pkg::RESET_IP + 32'h1f0;
    br_tgt[0]  = frontend_pkg::RESET_IP;
    br_bias[0] = 4;
    for (int i = 1; i < NUM_BR; i++) begin
      br_ip[i]   = frontend_pkg::RESET_IP + (32'($random(seed) & 31) << 4);
      br_tgt[i]  = frontend_pkg::RESET_IP + (32'($random(seed) & 31) << 4);
      br_bias[i] = $random(seed) & 3;
    end
  endtask

  task automatic reset_model();
    m_ip       = frontend_pkg::RESET_IP;
    m_hist     = '0;
    m_active   = 1'b0;
    m_q.delete();
    m_redir    = 1'b0;
    m_redir_ip = '0;
    m_tr_en    = 1'b0;
    m_tr_taken = 1'b0;
    m_tr_ip    = '0;
    m_tr_tgt   = '0;
    m_tr_hist  = '0;
    for (int i = 0; i < BTB_ENTRIES; i++) begin
      m_btb_valid[i] = 1'b0;
      m_btb_tag[i]   = 0;
      m_btb_tgt[i]   = '0;
    end
    for (int i = 0; i < PHT_ENTRIES; i++) m_pht[i] = frontend_pkg::CTR_INIT;
  endtask

  // first matching entry wins and unknown blocks fall through
  task automatic lookup_outcome(input frontend_pkg::ip_t ip, output logic taken,
                                output frontend_pkg::ip_t tgt);
    int hit_i;
    hit_i = -1;
    for (int i = NUM_BR-1; i >= 0; i--) begin
      if (br_ip[i] == ip) hit_i = i;
    end
    taken = 1'b0;
    tgt   = ip + STEP;
    if (hit_i >= 0) begin
      taken = ($random(seed) & 3) < br_bias[hit_i];
      tgt   = br_tgt[hit_i];
    end
  endtask

  task automatic compare_outputs();
    logic                     hv;
    frontend_pkg::fetch_pkt_t hd;
    hv = (m_q.size() != 0) && !m_redir;
    check_val(head_valid, hv, "head_valid");
    check_val(redirect, m_redir, "redirect");
    if (m_redir) check_val(redirect_ip, m_redir_ip, "redirect_ip");
    if (hv) begin
      hd = m_q[0];
      if (!seen_head) check_val(head_ip, frontend_pkg::RESET_IP, "first head ip");
      seen_head = 1'b1;
      check_val(head_ip, hd[frontend_pkg::PKT_IP_LSB +: frontend_pkg::IP_W], "head_ip");
      check_val(head_pred_taken, hd[frontend_pkg::PKT_TAKEN_BIT], "head_pred_taken");
      check_val(head_pred_target, hd[frontend_pkg::PKT_TGT_LSB +: frontend_pkg::IP_W],
                "head_pred_target");
    end
    if (m_q.size() == QUEUE_DEPTH) saw_full = 1'b1;
  endtask

  // advance the model over one rising edge with the inputs now driven
  task automatic step_model(input logic res, input logic at, input frontend_pkg::ip_t atgt);
    logic                     hv;
    logic                     pop;
    logic                     push;
    logic                     hit;
    logic                     ptaken;
    logic                     mis;
    frontend_pkg::ip_t        nxt;
    frontend_pkg::ip_t        hip;
    frontend_pkg::fetch_pkt_t hd;
    int unsigned              bi;
    int unsigned              pi;
    hv     = (m_q.size() != 0) && !m_redir;
    pop    = res && hv;
    push   = m_active && (m_q.size() < QUEUE_DEPTH) && !m_redir;
    bi     = btb_idx(m_ip);
    hit    = m_btb_valid[bi] && (m_btb_tag[bi] == btb_tag(m_ip));
    ptaken = hit && m_pht[pht_idx(m_ip, m_hist)][1];
    nxt    = ptaken ? m_btb_tgt[bi] : m_ip + STEP;
    mis    = 1'b0;
    if (m_tr_en) begin  // training from last resolve
      pi = pht_idx(m_tr_ip, m_tr_hist);
      if (m_tr_taken && m_pht[pi] != 2'b11) m_pht[pi] = m_pht[pi] + 2'd1;
      if (!m_tr_taken && m_pht[pi] != 2'b00) m_pht[pi] = m_pht[pi] - 2'd1;
      if (m_tr_taken) begin
        m_btb_valid[btb_idx(m_tr_ip)] = 1'b1;
        m_btb_tag[btb_idx(m_tr_ip)]   = btb_tag(m_tr_ip);
        m_btb_tgt[btb_idx(m_tr_ip)]   = m_tr_tgt;
      end
    end
    if (m_redir) begin
      m_q.delete();
      m_ip   = m_redir_ip;
      m_hist = {m_tr_hist[HW-2:0], m_tr_taken};
    end else begin
      if (pop) begin
        hd  = m_q.pop_front();
        hip = hd[frontend_pkg::PKT_IP_LSB +: frontend_pkg::IP_W];
        mis = (hd[frontend_pkg::PKT_TAKEN_BIT] != at) ||
              (hd[frontend_pkg::PKT_TAKEN_BIT] && at &&
               hd[frontend_pkg::PKT_TGT_LSB +: frontend_pkg::IP_W] != atgt);
        m_redir_ip = at ? atgt : hip + STEP;
        m_tr_ip    = hip;
        m_tr_taken = at;
        m_tr_tgt   = atgt;
        m_tr_hist  = hd[frontend_pkg::PKT_HIST_LSB +: HW];
      end
      if (push) begin
        m_q.push_back({m_ip, nxt, ptaken, m_hist});
        m_ip   = nxt;
        m_hist = {m_hist[HW-2:0], ptaken};
      end
    end
    m_redir  = pop && mis;
    m_tr_en  = pop;
    m_active = 1'b1;
  endtask

  initial begin
    logic              do_res;
    logic              tk;
    frontend_pkg::ip_t tg;
    frontend_pkg::fetch_pkt_t hd;
    rst           = 1'b1;
    resolve       = 1'b0;
    actual_taken  = 1'b0;
    actual_target = '0;
    err_count     = 0;
    resolves      = 0;
    cycle         = 0;
    saw_full      = 1'b0;
    seen_head     = 1'b0;
    init_branches();
    reset_model();
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    while (resolves < NUM_RESOLVES) begin
      compare_outputs();
      // resolves held back for a stretch so the queue fills
      do_res = (m_q.size() != 0) && !m_redir && ((cycle % 200) < 170) &&
               (($random(seed) & 1) != 0);
      tk = 1'b0;
      tg = '0;
      if (do_res) begin
        hd = m_q[0];
        lookup_outcome(hd[frontend_pkg::PKT_IP_LSB +: frontend_pkg::IP_W], tk, tg);
        resolves++;
      end
      resolve       = do_res;
      actual_taken  = tk;
      actual_target = tg;
      step_model(do_res, tk, tg);
      cycle++;
      @(negedge clk);
    end
    resolve = 1'b0;
    compare_outputs();
    check_val(saw_full, 1'b1, "queue reached full depth");
    if (err_count == 0) begin
      $display("All checks passed");
      $finish;
    end else begin
      $display("Checks failed");
      $fatal(1, "errors were found");
    end
  end

endmodule
